//--- org16_core.f
verilog/org16_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/address_unit.sv
verilog/sequencer.sv
verilog/org16_core.sv
verification/tb_clock_gen.sv
verification/org16_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the org16 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f org16_core.f \
	--top-module org16_core_tb -Mdir obj_dir -o org16_sim

out=$(./obj_dir/org16_sim)
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi

//--- verification/org16_core_tb.sv
/*
 * Testbench for the org16 core
 * Memory model with write monitor, a table of small programs applied one
 * per reset, expected stores worked out from the instruction rules
 */
`timescale 1ns/1ps

module org16_core_tb;
	import org16_pkg::*;

	localparam int k_ldst = 0;
	localparam int k_adc = 1;
	localparam int k_sbc = 2;
	localparam int k_and = 3;
	localparam int k_ora = 4;
	localparam int k_eor = 5;
	localparam int k_xfer = 6;
	localparam int k_beq = 7;
	localparam int k_bne = 8;
	localparam int k_bcs = 9;
	localparam int k_bmi = 10;
	localparam int k_jmp = 11;

	localparam addr_t prog_base = 32'h0000_0100;   // Vector target
	localparam addr_t halt_addr = 32'h0000_01f0;   // Jump-to-self loop
	localparam addr_t far_addr = 32'h0000_0a00;
	localparam addr_t preset_addr = 32'h0000_0300; // Absolute operands
	localparam addr_t store_addr = 32'h0000_0400;  // Store target m

	typedef struct {
		int    kind;
		word_t a;
		word_t b;
		logic  cin;                          // CLC or SEC before arithmetic
		logic  abs_mode;                     // Absolute operand, else immediate
	} row_t;

	logic   clk;
	logic   reset;
	addr_t  ab;
	word_t  di;
	word_t  do_data;
	logic   we;

	word_t  mem [0:4095];                  // Low 12 address bits
	int     p;                             // Assembly pointer
	row_t   table_q[$];
	addr_t  exp_addr[$];
	word_t  exp_data[$];
	addr_t  wr_addr[$];
	word_t  wr_data[$];
	addr_t  ab_log[$];                     // Addresses after reset release
	addr_t  s_ab;
	logic   s_we;
	word_t  s_do;
	int     errors;
	int     timeouts;
	integer seed;

	tb_clock_gen clk_gen_i (.clk(clk), .reset(reset));

	org16_core org16_core_i (
		.clk     (clk),
		.reset   (reset),
		.ab      (ab),
		.di      (di),
		.do_data (do_data),
		.we      (we)
	);

	function automatic word_t read_word(addr_t a);
		if (a == reset_vector)
			return prog_base[15:0];
		if (a == reset_vector + 32'd1)
			return prog_base[31:16];
		if (a[31:12] == 20'd0)
			return mem[a[11:0]];
		return a[15:0] ^ a[31:16];           // Unmapped space
	endfunction

	// Bus sampled mid cycle where it is stable
	always @(negedge clk) begin
		s_ab = ab;
		s_we = we;
		s_do = do_data;
		if (!reset)
			ab_log.push_back(ab);
		if (reset && we) begin
			$display("Write enable seen high while reset is asserted at %0t ns", $time);
			errors++;
		end
	end

	// Write and read answer 10 ns after the edge
	always @(posedge clk) begin
		#10;
		if (s_we) begin
			if (s_ab[31:12] == 20'd0)
				mem[s_ab[11:0]] = s_do;
			wr_addr.push_back(s_ab);
			wr_data.push_back(s_do);
		end
		di = read_word(s_ab);
	end

	task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic word_t expect_alu(int kind, word_t a, word_t b, logic cin);
		case (kind)
			k_adc:   return a + b + {15'd0, cin};
			k_sbc:   return a + ~b + {15'd0, cin};   // Borrow is inverted carry
			k_and:   return a & b;
			k_ora:   return a | b;
			k_eor:   return a ^ b;
			default: return a;
		endcase
	endfunction

	function automatic logic branch_taken(row_t r);
		logic [16:0] sum;
		sum = {1'b0, r.a} + {1'b0, r.b};
		case (r.kind)
			k_beq:   return r.a == r.b;          // Z set when equal
			k_bne:   return r.a != r.b;
			k_bcs:   return sum[16];             // Carry out of ADC
			default: return r.a[15];             // N from bit 15
		endcase
	endfunction

	function automatic word_t pick_opcode(int kind, logic abs_mode);
		case (kind)
			k_adc:   return abs_mode ? OPC_ADC_ABS : OPC_ADC_IMM;
			k_sbc:   return abs_mode ? OPC_SBC_ABS : OPC_SBC_IMM;
			k_and:   return abs_mode ? OPC_AND_ABS : OPC_AND_IMM;
			k_ora:   return abs_mode ? OPC_ORA_ABS : OPC_ORA_IMM;
			k_eor:   return abs_mode ? OPC_EOR_ABS : OPC_EOR_IMM;
			k_beq:   return OPC_BEQ;
			k_bne:   return OPC_BNE;
			k_bcs:   return OPC_BCS;
			default: return OPC_BMI;
		endcase
	endfunction

	task emit(input word_t w);
		mem[p] = w;
		p = p + 1;
	endtask

	task emit_abs(input word_t opc, input addr_t target);
		emit(opc);
		emit(target[15:0]);                  // Low half first
		emit(target[31:16]);
	endtask

	task expect_write(input addr_t a, input word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task build_program(input row_t r);
		for (int i = 0; i < 4096; i++)
			mem[i] = word_t'(i) ^ 16'h5a00;
		p = int'(prog_base[11:0]);
		case (r.kind)
			k_ldst: begin
				mem[preset_addr[11:0]] = ~r.a;
				emit(OPC_LDA_IMM);
				emit(r.a);
				emit_abs(OPC_STA_ABS, store_addr);
				emit(OPC_LDX_IMM);
				emit(r.b);
				emit_abs(OPC_STX_ABS, store_addr + 32'd1);
				emit_abs(OPC_LDY_ABS, preset_addr);
				emit_abs(OPC_STY_ABS, store_addr + 32'd2);
				expect_write(store_addr, r.a);
				expect_write(store_addr + 32'd1, r.b);
				expect_write(store_addr + 32'd2, ~r.a);
			end
			k_adc, k_sbc, k_and, k_ora, k_eor: begin
				emit(r.cin ? OPC_SEC : OPC_CLC);
				emit(OPC_LDA_IMM);
				emit(r.a);
				if (r.abs_mode) begin
					mem[preset_addr[11:0]] = r.b;
					emit_abs(pick_opcode(r.kind, 1'b1), preset_addr);
				end else begin
					emit(pick_opcode(r.kind, 1'b0));
					emit(r.b);
				end
				emit_abs(OPC_STA_ABS, store_addr);
				expect_write(store_addr, expect_alu(r.kind, r.a, r.b, r.cin));
			end
			k_xfer: begin
				emit(OPC_LDA_IMM);
				emit(r.a);
				emit(OPC_TAY);
				emit(OPC_TAX);
				emit(OPC_INX);
				emit(OPC_TXA);
				emit_abs(OPC_STA_ABS, store_addr);    // k+1
				emit(OPC_DEY);
				emit(OPC_DEY);
				emit_abs(OPC_STY_ABS, store_addr + 32'd1);  // k-2
				expect_write(store_addr, r.a + 16'd1);
				expect_write(store_addr + 32'd1, r.a - 16'd2);
			end
			k_beq, k_bne, k_bcs, k_bmi: begin
				if (r.kind == k_bcs) begin
					emit(OPC_CLC);
					emit(OPC_LDA_IMM);
					emit(r.a);
					emit(OPC_ADC_IMM);
					emit(r.b);
				end else begin
					emit(OPC_LDA_IMM);
					emit(r.a);
					if (r.kind != k_bmi) begin
						emit(OPC_CMP_IMM);
						emit(r.b);
					end
				end
				emit(pick_opcode(r.kind, 1'b0));
				emit(16'd8);                     // Skips marker 1 path
				emit(OPC_LDA_IMM);
				emit(16'd1);
				emit_abs(OPC_STA_ABS, store_addr);
				emit_abs(OPC_JMP_ABS, halt_addr);
				emit(OPC_LDA_IMM);
				emit(16'd2);
				emit_abs(OPC_STA_ABS, store_addr);
				expect_write(store_addr, branch_taken(r) ? 16'd2 : 16'd1);
			end
			default: begin
				emit_abs(OPC_JMP_ABS, far_addr);
				emit(OPC_LDA_IMM);
				emit(16'hdead);                  // Never stored
				emit_abs(OPC_STA_ABS, store_addr);
				p = int'(far_addr[11:0]);
				emit(OPC_LDA_IMM);
				emit(r.a);
				emit_abs(OPC_STA_ABS, store_addr);
				expect_write(store_addr, r.a);
			end
		endcase
		emit_abs(OPC_JMP_ABS, halt_addr);
		p = int'(halt_addr[11:0]);
		emit_abs(OPC_JMP_ABS, halt_addr);    // Park here
	endtask

	task add_row(input int kind, input word_t a, input word_t b, input logic cin,
		input logic abs_mode);
		row_t r;
		r.kind = kind;
		r.a = a;
		r.b = b;
		r.cin = cin;
		r.abs_mode = abs_mode;
		table_q.push_back(r);
	endtask

	task run_row(input int idx, input row_t r);
		int cycles;
		clk_gen_i.start_reset();
		@(negedge clk);
		exp_addr.delete();
		exp_data.delete();
		wr_addr.delete();
		wr_data.delete();
		ab_log.delete();
		build_program(r);
		clk_gen_i.finish_reset();
		cycles = 0;
		while (wr_addr.size() < exp_addr.size() && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (wr_addr.size() < exp_addr.size()) begin
			$display("Row %0d: timeout waiting for store", idx);
			timeouts++;
		end else begin
			repeat (20) @(posedge clk);        // Catch stray stores
			check_value(wr_addr.size(), exp_addr.size(),
				$sformatf("row %0d write count", idx));
			for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++) begin
				check_value(wr_addr[i], exp_addr[i],
					$sformatf("row %0d write %0d address", idx, i));
				check_value({16'd0, wr_data[i]}, {16'd0, exp_data[i]},
					$sformatf("row %0d write %0d data", idx, i));
			end
			check_value(ab_log[0], reset_vector,
				$sformatf("row %0d first address", idx));
			check_value(ab_log[1], reset_vector + 32'd1,
				$sformatf("row %0d second address", idx));
			check_value(ab_log[2], prog_base,
				$sformatf("row %0d vector target", idx));
		end
	endtask

	initial begin
		di = '0;
		s_ab = '0;
		s_we = 1'b0;
		s_do = '0;
		errors = 0;
		timeouts = 0;
		seed = 32'h5348;
		add_row(k_ldst, 16'h1234, 16'h0bee, 1'b0, 1'b0);
		add_row(k_adc, 16'h1234, 16'h0f0f, 1'b0, 1'b0);
		add_row(k_adc, 16'hffff, 16'h0001, 1'b1, 1'b1);   // Wraps past 16 bits
		add_row(k_adc, word_t'($random(seed)), word_t'($random(seed)), 1'b1, 1'b1);
		add_row(k_sbc, 16'h5000, 16'h1234, 1'b1, 1'b0);
		add_row(k_sbc, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b1);
		add_row(k_and, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b0);
		add_row(k_ora, word_t'($random(seed)), word_t'($random(seed)), 1'b1, 1'b1);
		add_row(k_eor, word_t'($random(seed)), word_t'($random(seed)), 1'b0, 1'b0);
		add_row(k_eor, 16'haaaa, 16'h0ff0, 1'b0, 1'b1);
		add_row(k_xfer, 16'hffff, 16'h0000, 1'b0, 1'b0);  // X wraps to zero
		add_row(k_xfer, 16'h0001, 16'h0000, 1'b0, 1'b0);  // Y wraps below zero
		add_row(k_beq, 16'h0055, 16'h0055, 1'b0, 1'b0);
		add_row(k_beq, 16'h0055, 16'h0056, 1'b0, 1'b0);
		add_row(k_bne, 16'h8000, 16'h0001, 1'b0, 1'b0);
		add_row(k_bne, 16'h7777, 16'h7777, 1'b0, 1'b0);
		add_row(k_bcs, 16'hf000, 16'h2000, 1'b0, 1'b0);
		add_row(k_bcs, 16'h1000, 16'h2000, 1'b0, 1'b0);
		add_row(k_bmi, 16'h8001, 16'h0000, 1'b0, 1'b0);
		add_row(k_bmi, 16'h7fff, 16'h0000, 1'b0, 1'b0);
		add_row(k_jmp, 16'h0c0d, 16'h0000, 1'b0, 1'b0);
		foreach (table_q[i])
			run_row(i, table_q[i]);
		$display("Result: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * 100 ns clock, reset held for three cycles on request
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		reset = 1'b1;                        // Held until the first run releases it
	end

	always #50 clk = ~clk;                 // 100 ns period

	task start_reset();
		@(posedge clk);
		#10;
		reset = 1'b1;
	endtask

	task finish_reset();
		repeat (3) @(posedge clk);           // Three cycles in reset
		#10;
		reset = 1'b0;
	endtask

endmodule

//--- verilog/org16_core.sv
/*
 * org16 CPU core top level
 * Sequencer plus address unit, register file and ALU on a plain
 * address/data/write-enable memory bus
 */
`timescale 1ns/1ps

module org16_core (
	input  logic             clk,
	input  logic             reset,
	output org16_pkg::addr_t ab,          // Word address
	input  org16_pkg::word_t di,          // Read data, one cycle after ab
	output org16_pkg::word_t do_data,     // Write data
	output logic             we           // Write at ab on this edge
);
	import org16_pkg::*;

	addr_ctrl_t addr_ctrl;
	alu_ctrl_t  alu_ctrl;
	reg_ctrl_t  reg_ctrl;
	status_t    status;
	alu_out_t   alu_out;

	sequencer sequencer_i (
		.clk       (clk),
		.reset     (reset),
		.di        (di),
		.status    (status),
		.alu_out   (alu_out),
		.addr_ctrl (addr_ctrl),
		.alu_ctrl  (alu_ctrl),
		.reg_ctrl  (reg_ctrl),
		.we        (we)
	);

	address_unit address_unit_i (
		.clk       (clk),
		.reset     (reset),
		.addr_ctrl (addr_ctrl),
		.di        (di),
		.alu_out   (alu_out),
		.ab        (ab)
	);

	register_file register_file_i (
		.clk      (clk),
		.reset    (reset),
		.reg_ctrl (reg_ctrl),
		.alu_out  (alu_out),
		.rd_data  (do_data),               // Read port doubles as store data
		.status   (status)
	);

	alu alu_i (
		.clk      (clk),
		.reset    (reset),
		.alu_ctrl (alu_ctrl),
		.rd_data  (do_data),
		.di       (di),
		.alu_out  (alu_out)
	);

endmodule

//--- verilog/sequencer.sv
/*
 * Microcode sequencer
 * Decodes the opcode word on di in DECODE, steps through the states of
 * each addressing mode and drives all datapath controls
 */
`timescale 1ns/1ps

module sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  org16_pkg::word_t      di,
	input  org16_pkg::status_t    status,
	input  org16_pkg::alu_out_t   alu_out,
	output org16_pkg::addr_ctrl_t addr_ctrl,
	output org16_pkg::alu_ctrl_t  alu_ctrl,
	output org16_pkg::reg_ctrl_t  reg_ctrl,
	output logic                  we
);
	import org16_pkg::*;

	typedef struct packed {
		reg_sel_t   src;                     // Read in FETCH, REG and ABS1
		reg_sel_t   dst;                     // Written in the next DECODE
		alu_op_t    op;
		logic       store;
		logic       load_only;
		logic       compare;                 // CMP, flags only
		logic       arith;                   // ADC or SBC
		logic       write;                   // Register write back
		logic       clc;
		logic       sec;
		logic [2:0] cond;                    // Branch condition bits 7:5
	} dec_t;

	state_t   state;
	state_t   dec_next;                    // State after DECODE
	dec_t     dec;
	dec_t     dec_q;                       // Fields of instruction in flight
	reg_sel_t col_reg;                     // Register from low opcode bits
	logic     flag_sel;
	logic     cond_true;

	// 01 is A, 10 is X, 00 is Y for loads and stores
	assign col_reg = (di[1:0] == 2'b10) ? REG_X : ((di[1:0] == 2'b00) ? REG_Y : REG_A);

	always_comb begin
		dec = '0;
		dec.cond = di[7:5];
		dec_next = REG;                      // Unknown words run as a no-op
		case (di)
			OPC_LDA_IMM, OPC_LDA_ABS, OPC_LDX_IMM, OPC_LDX_ABS,
			OPC_LDY_IMM, OPC_LDY_ABS: begin
				dec.dst = col_reg;
				dec.load_only = 1'b1;
				dec.write = 1'b1;
				dec_next = di[2] ? ABS0 : FETCH;  // Bit 2 marks absolute
			end
			OPC_STA_ABS, OPC_STX_ABS, OPC_STY_ABS: begin
				dec.src = col_reg;
				dec.store = 1'b1;
				dec_next = ABS0;
			end
			OPC_ORA_IMM, OPC_ORA_ABS, OPC_AND_IMM, OPC_AND_ABS, OPC_EOR_IMM, OPC_EOR_ABS,
			OPC_ADC_IMM, OPC_ADC_ABS, OPC_SBC_IMM, OPC_SBC_ABS, OPC_CMP_IMM, OPC_CMP_ABS: begin
				dec.op = di[7] ? OP_SUB : alu_op_t'({1'b0, di[6:5]});  // CMP, SBC subtract
				dec.compare = (di[7:5] == 3'b110);
				dec.arith = (di[6:5] == 2'b11);
				dec.write = (di[7:5] != 3'b110);
				dec_next = di[2] ? ABS0 : FETCH;
			end
			OPC_INX, OPC_INY, OPC_DEX, OPC_DEY: begin
				dec.src = (di == OPC_INX || di == OPC_DEX) ? REG_X : REG_Y;
				dec.dst = dec.src;
				dec.op = (di == OPC_DEX || di == OPC_DEY) ? OP_SUB : OP_ADD;
				dec.write = 1'b1;
			end
			OPC_TAX, OPC_TAY, OPC_TXA, OPC_TYA: begin
				dec.src = (di == OPC_TXA) ? REG_X : ((di == OPC_TYA) ? REG_Y : REG_A);
				dec.dst = (di == OPC_TAX) ? REG_X : ((di == OPC_TAY) ? REG_Y : REG_A);
				dec.op = OP_OR;                  // OR with zero passes the source
				dec.write = 1'b1;
			end
			OPC_CLC: dec.clc = 1'b1;
			OPC_SEC: dec.sec = 1'b1;
			OPC_JMP_ABS: dec_next = JMP0;
			OPC_BPL, OPC_BMI, OPC_BVC, OPC_BVS,
			OPC_BCC, OPC_BCS, OPC_BNE, OPC_BEQ: dec_next = BRA0;
			default: ;
		endcase
	end

	// Bits 7:6 pick the flag, bit 5 the polarity
	always_comb begin
		case (dec_q.cond[2:1])
			2'b00:   flag_sel = status.n;
			2'b01:   flag_sel = status.v;
			2'b10:   flag_sel = status.c;
			default: flag_sel = status.z;
		endcase
	end

	assign cond_true = (flag_sel == dec_q.cond[0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= VEC;
			dec_q <= '0;                       // No write back before first instruction
		end else begin
			if (state == DECODE)
				dec_q <= dec;
			case (state)
				VEC:     state <= JMP0;
				JMP0:    state <= JMP1;
				DECODE:  state <= dec_next;
				ABS0:    state <= ABS1;
				ABS1:    state <= FETCH;
				BRA0:    state <= cond_true ? BRA1 : DECODE;
				default: state <= DECODE;        // JMP1, FETCH, REG, BRA1
			endcase
		end
	end

	always_comb begin
		addr_ctrl.addr_sel = AB_PC;
		addr_ctrl.pc_sel = PC_KEEP_SRC;
		addr_ctrl.pc_inc = 1'b1;             // Most states step the PC
		alu_ctrl.op = dec_q.op;
		alu_ctrl.ai_zero = 1'b1;
		alu_ctrl.bi_di = 1'b1;
		alu_ctrl.ci = 1'b0;
		alu_ctrl.en = 1'b0;
		reg_ctrl = '0;
		reg_ctrl.rd_sel = dec_q.src;
		reg_ctrl.wr_sel = dec_q.dst;
		we = 1'b0;
		case (state)
			VEC: begin
				addr_ctrl.addr_sel = AB_VECTOR;
				addr_ctrl.pc_sel = PC_VECTOR;
			end
			JMP0, ABS0: begin
				alu_ctrl.op = OP_OR;             // Park low address word in ALU
				alu_ctrl.en = 1'b1;
			end
			JMP1: begin
				addr_ctrl.addr_sel = AB_ABS;
				addr_ctrl.pc_sel = PC_ABS;
			end
			DECODE: begin                      // Retire previous instruction
				reg_ctrl.wr_en = dec_q.write;
				reg_ctrl.nz_we = dec_q.write | dec_q.compare;
				reg_ctrl.c_we = dec_q.arith | dec_q.compare | dec_q.clc | dec_q.sec;
				reg_ctrl.v_we = dec_q.arith;
				reg_ctrl.c_force = dec_q.clc | dec_q.sec;
				reg_ctrl.c_value = dec_q.sec;
			end
			FETCH: begin
				alu_ctrl.ai_zero = dec_q.load_only;
				alu_ctrl.ci = dec_q.compare | (dec_q.arith & status.c);
				alu_ctrl.en = 1'b1;
			end
			ABS1: begin
				addr_ctrl.addr_sel = AB_ABS;
				addr_ctrl.pc_inc = 1'b0;
				we = dec_q.store;
			end
			REG: begin
				addr_ctrl.addr_sel = AB_HOLD;     // Refetch next opcode
				addr_ctrl.pc_inc = 1'b0;
				alu_ctrl.ai_zero = 1'b0;
				alu_ctrl.bi_di = 1'b0;
				alu_ctrl.ci = (dec_q.op == OP_ADD);  // Increment
				alu_ctrl.en = 1'b1;
			end
			BRA0: if (cond_true) begin
				addr_ctrl.pc_sel = PC_BRANCH;
				addr_ctrl.pc_inc = 1'b0;
			end
			default: ;                         // BRA1 fetches at the target
		endcase
	end

	a_we_in_abs1: assert property (@(posedge clk) disable iff (reset)
		we |-> state == ABS1);
	a_vec_to_jmp0: assert property (@(posedge clk) disable iff (reset)
		state == VEC |=> state == JMP0);

endmodule

//--- verilog/address_unit.sv
/*
 * Address unit
 * Program counter with branch adder, previous-address hold and the
 * address bus source mux
 */
`timescale 1ns/1ps

module address_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  org16_pkg::addr_ctrl_t addr_ctrl,
	input  org16_pkg::word_t      di,
	input  org16_pkg::alu_out_t   alu_out,
	output org16_pkg::addr_t      ab
);
	import org16_pkg::*;

	addr_t pc;
	addr_t hold;                           // Address of last cycle
	addr_t abs_addr;                       // High half di, low half ALU
	addr_t branch_addr;
	addr_t pc_base;

	assign abs_addr = {di, alu_out.result};

	// Offset is relative to the word after the offset
	assign branch_addr = pc + {{(addr_w - word_w){di[word_w-1]}}, di};

	always_comb begin
		case (addr_ctrl.addr_sel)
			AB_HOLD:   ab = hold;
			AB_VECTOR: ab = reset_vector;
			AB_ABS:    ab = abs_addr;
			default:   ab = pc;
		endcase
	end

	always_comb begin
		case (addr_ctrl.pc_sel)
			PC_VECTOR: pc_base = reset_vector;
			PC_ABS:    pc_base = abs_addr;
			PC_BRANCH: pc_base = branch_addr;
			default:   pc_base = pc;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_base + addr_t'(addr_ctrl.pc_inc);
	end

	always_ff @(posedge clk)
		hold <= ab;                          // Replayed in REG

	a_ab_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(ab));

endmodule

//--- verilog/register_file.sv
/*
 * Register file
 * A, X and Y registers with a single read port, plus the N, V, Z and C
 * status flags written from the registered ALU result
 */
`timescale 1ns/1ps

module register_file (
	input  logic                 clk,
	input  logic                 reset,
	input  org16_pkg::reg_ctrl_t reg_ctrl,
	input  org16_pkg::alu_out_t  alu_out,
	output org16_pkg::word_t     rd_data,
	output org16_pkg::status_t   status
);
	import org16_pkg::*;

	word_t a;
	word_t x;
	word_t y;

	always_comb begin
		case (reg_ctrl.rd_sel)
			REG_X:   rd_data = x;
			REG_Y:   rd_data = y;
			default: rd_data = a;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			a <= '0;
			x <= '0;
			y <= '0;
		end else if (reg_ctrl.wr_en) begin
			case (reg_ctrl.wr_sel)
				REG_X:   x <= alu_out.result;
				REG_Y:   y <= alu_out.result;
				default: a <= alu_out.result;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			status <= '0;
		end else begin
			if (reg_ctrl.nz_we) begin
				status.n <= alu_out.result[word_w-1];   // Sign bit
				status.z <= (alu_out.result == '0);
			end
			if (reg_ctrl.c_we)
				status.c <= reg_ctrl.c_force ? reg_ctrl.c_value : alu_out.co;  // CLC/SEC or carry
			if (reg_ctrl.v_we)
				status.v <= alu_out.v;
		end
	end

	a_wr_sel_legal: assert property (@(posedge clk) disable iff (reset)
		reg_ctrl.wr_en |-> reg_ctrl.wr_sel inside {REG_A, REG_X, REG_Y});

endmodule

//--- verilog/alu.sv
/*
 * ALU
 * Operand muxes, 16-bit adder with carry and overflow and the logic ops,
 * result registered when enabled
 */
`timescale 1ns/1ps

module alu (
	input  logic                 clk,
	input  logic                 reset,
	input  org16_pkg::alu_ctrl_t alu_ctrl,
	input  org16_pkg::word_t     rd_data,
	input  org16_pkg::word_t     di,
	output org16_pkg::alu_out_t  alu_out
);
	import org16_pkg::*;

	word_t           ai;
	word_t           bi;
	logic [word_w:0] sum;                  // Carry in the top bit
	word_t           result;

	assign ai = alu_ctrl.ai_zero ? '0 : rd_data;

	always_comb begin
		bi = alu_ctrl.bi_di ? di : '0;
		if (alu_ctrl.op == OP_SUB)
			bi = ~bi;                          // Subtract as A + ~B + C
	end

	assign sum = {1'b0, ai} + {1'b0, bi} + {{word_w{1'b0}}, alu_ctrl.ci};

	always_comb begin
		case (alu_ctrl.op)
			OP_OR:   result = ai | bi;
			OP_AND:  result = ai & bi;
			OP_EOR:  result = ai ^ bi;
			default: result = sum[word_w-1:0];
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			alu_out <= '0;
		end else if (alu_ctrl.en) begin
			alu_out.result <= result;
			alu_out.co <= sum[word_w];
			// Same operand signs, result sign differs
			alu_out.v <= (ai[word_w-1] == bi[word_w-1]) && (sum[word_w-1] != ai[word_w-1]);
		end
	end

endmodule

//--- verilog/org16_pkg.sv
/*
 * Shared definitions for the org16 core
 * Word and address widths, sequencer states, datapath control structs,
 * status flags, the reset vector and the 6502-style opcode words
 */
package org16_pkg;

	localparam int word_w = 16;                   // Data word
	localparam int addr_w = 32;                   // Word address

	typedef logic [word_w-1:0] word_t;
	typedef logic [addr_w-1:0] addr_t;

	localparam addr_t reset_vector = 32'hffff_fffc;   // Low half of start address, high half next

	typedef enum logic [3:0] {VEC, JMP0, JMP1, DECODE, FETCH, ABS0, ABS1, REG, BRA0, BRA1} state_t;
	typedef enum logic [1:0] {REG_A, REG_X, REG_Y} reg_sel_t;
	typedef enum logic [2:0] {OP_OR, OP_AND, OP_EOR, OP_ADD, OP_SUB} alu_op_t;  // SUB adds ~B
	typedef enum logic [2:0] {AB_PC, AB_HOLD, AB_VECTOR, AB_ABS} addr_sel_t;
	typedef enum logic [1:0] {PC_KEEP_SRC, PC_VECTOR, PC_ABS, PC_BRANCH} pc_sel_t;

	typedef struct packed {
		addr_sel_t addr_sel;                      // Address bus source
		pc_sel_t   pc_sel;                        // PC load source
		logic      pc_inc;                        // Add one to the loaded PC
	} addr_ctrl_t;

	typedef struct packed {
		alu_op_t op;
		logic    ai_zero;                         // A operand is zero, not the register
		logic    bi_di;                           // B operand is di, else zero
		logic    ci;                              // Carry in
		logic    en;                              // Capture result at clock edge
	} alu_ctrl_t;

	typedef struct packed {
		reg_sel_t rd_sel;                         // Read port for ALU and stores
		reg_sel_t wr_sel;
		logic     wr_en;
		logic     nz_we;
		logic     c_we;
		logic     v_we;
		logic     c_force;                        // C from c_value, not the ALU
		logic     c_value;
	} reg_ctrl_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} status_t;

	typedef struct packed {
		word_t result;
		logic  co;                                // Carry out of the adder
		logic  v;                                 // Signed overflow
	} alu_out_t;

	// Classic 6502 encodings in the low byte
	localparam word_t OPC_LDA_IMM = 16'h00a9;
	localparam word_t OPC_LDA_ABS = 16'h00ad;
	localparam word_t OPC_LDX_IMM = 16'h00a2;
	localparam word_t OPC_LDX_ABS = 16'h00ae;
	localparam word_t OPC_LDY_IMM = 16'h00a0;
	localparam word_t OPC_LDY_ABS = 16'h00ac;
	localparam word_t OPC_STA_ABS = 16'h008d;
	localparam word_t OPC_STX_ABS = 16'h008e;
	localparam word_t OPC_STY_ABS = 16'h008c;
	localparam word_t OPC_ORA_IMM = 16'h0009;
	localparam word_t OPC_ORA_ABS = 16'h000d;
	localparam word_t OPC_AND_IMM = 16'h0029;
	localparam word_t OPC_AND_ABS = 16'h002d;
	localparam word_t OPC_EOR_IMM = 16'h0049;
	localparam word_t OPC_EOR_ABS = 16'h004d;
	localparam word_t OPC_ADC_IMM = 16'h0069;
	localparam word_t OPC_ADC_ABS = 16'h006d;
	localparam word_t OPC_CMP_IMM = 16'h00c9;
	localparam word_t OPC_CMP_ABS = 16'h00cd;
	localparam word_t OPC_SBC_IMM = 16'h00e9;
	localparam word_t OPC_SBC_ABS = 16'h00ed;
	localparam word_t OPC_INX = 16'h00e8;
	localparam word_t OPC_INY = 16'h00c8;
	localparam word_t OPC_DEX = 16'h00ca;
	localparam word_t OPC_DEY = 16'h0088;
	localparam word_t OPC_TAX = 16'h00aa;
	localparam word_t OPC_TAY = 16'h00a8;
	localparam word_t OPC_TXA = 16'h008a;
	localparam word_t OPC_TYA = 16'h0098;
	localparam word_t OPC_CLC = 16'h0018;
	localparam word_t OPC_SEC = 16'h0038;
	localparam word_t OPC_JMP_ABS = 16'h004c;
	localparam word_t OPC_BPL = 16'h0010;
	localparam word_t OPC_BMI = 16'h0030;
	localparam word_t OPC_BVC = 16'h0050;
	localparam word_t OPC_BVS = 16'h0070;
	localparam word_t OPC_BCC = 16'h0090;
	localparam word_t OPC_BCS = 16'h00b0;
	localparam word_t OPC_BNE = 16'h00d0;
	localparam word_t OPC_BEQ = 16'h00f0;

endpackage
